// File: common/tree_route_defines.svh
// tree shape macros and derived widths, included by the package and any RTL that sizes with them
`ifndef TREE_ROUTE_DEFINES_SVH
`define TREE_ROUTE_DEFINES_SVH

// ======================================================================
// tree shape
// ======================================================================

// endpoints per leaf router, children per router
`define TREE_K 2

// levels, 0 at the leaves and L-1 at the root
`define TREE_L 3

// ======================================================================
// derived widths
// ======================================================================

// one base-K address digit
`define TREE_KW ((`TREE_K > 2) ? $clog2(`TREE_K) : 1)

// level number 0 .. L-1
`define TREE_LW ((`TREE_L > 2) ? $clog2(`TREE_L) : 1)

// port number 0 .. K, where K is the up port
`define TREE_PW $clog2(`TREE_K + 1)

`endif

// File: common/tree_route_pkg.sv
// shared routing types and the nearest-common-ancestor port rule used by both pipeline stages
package tree_route_pkg;

`include "tree_route_defines.svh"

    // ======================================================================
    // types
    // ======================================================================

    typedef logic [`TREE_L*`TREE_KW-1:0] endpoint_addr_t; // L digits, d0 at the lsb
    typedef logic [`TREE_LW-1:0]         level_t;         // 0 at the leaves
    typedef logic [`TREE_PW-1:0]         port_t;          // 0..K-1 down, K up
    typedef logic [`TREE_K-1:0]          port_mask_t;     // one-hot, input port removed

    // four-phase handshake controller states
    typedef enum logic [1:0] {
        HS_IDLE,    // waiting for req
        HS_BUSY,    // request in the pipeline
        HS_DONE,    // ack high, results held
        HS_RELEASE  // req seen low, ack drops next
    } hs_state_t;

    // ======================================================================
    // nearest common ancestor rule
    // ======================================================================

    // down through d_lv when the digits above lv match the router, else up
    function automatic port_t nca_port(
        input level_t         lv,
        input endpoint_addr_t router_addr,
        input endpoint_addr_t dest
    );
        logic  mismatch;
        port_t port;
        mismatch = 1'b0;
        port     = '0;
        for (int i = 0; i < `TREE_L; i++) begin
            if (i > int'(lv) &&
                router_addr[i*`TREE_KW +: `TREE_KW] != dest[i*`TREE_KW +: `TREE_KW]) begin
                mismatch = 1'b1; // destination outside this subtree
            end
            if (i == int'(lv)) begin
                port = port_t'(dest[i*`TREE_KW +: `TREE_KW]);
            end
        end
        if (mismatch) begin
            port = port_t'(`TREE_K); // root never gets here
        end
        return port;
    endfunction

endpackage

// File: common/route_stage_if.sv
// carries one request's stage-1 routing results from nca_port_select to lookahead_route
`timescale 1ns/10ps

interface route_stage_if;

    logic                           stage_valid;      // one-cycle pulse per request
    tree_route_pkg::port_t          in_port;          // port the packet arrived on
    tree_route_pkg::endpoint_addr_t dest_addr;
    tree_route_pkg::port_t          dest_port;        // this router's output port
    tree_route_pkg::endpoint_addr_t next_addr;        // neighbor on dest_port
    tree_route_pkg::level_t         next_level;
    logic                           next_is_endpoint; // leaf going down

    modport producer (
        output stage_valid,
        output in_port,
        output dest_addr,
        output dest_port,
        output next_addr,
        output next_level,
        output next_is_endpoint
    );

    modport consumer (
        input stage_valid,
        input in_port,
        input dest_addr,
        input dest_port,
        input next_addr,
        input next_level,
        input next_is_endpoint
    );

endinterface

// File: logic/four_phase_ctrl.sv
// four-phase req/ack controller that launches one pipeline pass per request and holds ack
`timescale 1ns/10ps

module four_phase_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic req,
    input  logic result_valid,
    output logic launch,
    output logic ack
);

    tree_route_pkg::hs_state_t state;
    tree_route_pkg::hs_state_t state_next;

    // ======================================================================
    // next state
    // ======================================================================

    always_comb begin
        state_next = state;
        case (state)
            tree_route_pkg::HS_IDLE: begin
                if (req) begin
                    state_next = tree_route_pkg::HS_BUSY;
                end
            end
            tree_route_pkg::HS_BUSY: begin
                if (result_valid) begin
                    // req may already be low if it dropped right after ack
                    state_next = req ? tree_route_pkg::HS_DONE : tree_route_pkg::HS_RELEASE;
                end
            end
            tree_route_pkg::HS_DONE: begin
                if (!req) begin
                    state_next = tree_route_pkg::HS_RELEASE;
                end
            end
            tree_route_pkg::HS_RELEASE: begin
                state_next = tree_route_pkg::HS_IDLE; // ack drops here
            end
            default: begin
                state_next = tree_route_pkg::HS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= tree_route_pkg::HS_IDLE;
            launch <= 1'b0;
        end else begin
            state  <= state_next;
            launch <= (state == tree_route_pkg::HS_IDLE) && req; // single pulse
        end
    end

    // high from the result edge until the cycle after req falls
    assign ack = ((state == tree_route_pkg::HS_BUSY) && result_valid) ||
                 (state == tree_route_pkg::HS_DONE) ||
                 (state == tree_route_pkg::HS_RELEASE);

endmodule

// File: route/nca_port_select.sv
// first pipeline stage: picks this router's output port and predicts the neighbor on it
`timescale 1ns/10ps
`include "tree_route_defines.svh"

module nca_port_select #(
    parameter int ROUTER_LEVEL = 0,
    parameter int ROUTER_POS   = 0
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           launch,
    input  tree_route_pkg::endpoint_addr_t dest_addr,
    input  tree_route_pkg::port_t          in_port,
    route_stage_if.producer                stage
);

    localparam int KW = `TREE_KW;

    // base-K digit encoding of an endpoint index
    function automatic tree_route_pkg::endpoint_addr_t encode_addr(input int index);
        tree_route_pkg::endpoint_addr_t addr;
        int                             rest;
        addr = '0;
        rest = index;
        for (int i = 0; i < `TREE_L; i++) begin
            addr[i*KW +: KW] = KW'(rest % `TREE_K);
            rest             = rest / `TREE_K;
        end
        return addr;
    endfunction

    // address with one digit replaced, out-of-range index leaves it unchanged
    function automatic tree_route_pkg::endpoint_addr_t with_digit(
        input tree_route_pkg::endpoint_addr_t addr,
        input int                             idx,
        input logic [KW-1:0]                  digit
    );
        tree_route_pkg::endpoint_addr_t result;
        result = addr;
        for (int i = 0; i < `TREE_L; i++) begin
            if (i == idx) begin
                result[i*KW +: KW] = digit;
            end
        end
        return result;
    endfunction

    // ======================================================================
    // router constants
    // ======================================================================

    localparam tree_route_pkg::endpoint_addr_t ROUTER_ADDR =
        encode_addr(ROUTER_POS * (`TREE_K ** (ROUTER_LEVEL + 1))); // lowest endpoint below
    localparam tree_route_pkg::level_t LEVEL_V    = tree_route_pkg::level_t'(ROUTER_LEVEL);
    localparam tree_route_pkg::port_t  UP_PORT    = tree_route_pkg::port_t'(`TREE_K);
    localparam tree_route_pkg::level_t UP_LEVEL   = (ROUTER_LEVEL == `TREE_L - 1) ? LEVEL_V :
        tree_route_pkg::level_t'(ROUTER_LEVEL + 1);
    localparam tree_route_pkg::level_t DOWN_LEVEL = (ROUTER_LEVEL == 0) ? LEVEL_V :
        tree_route_pkg::level_t'(ROUTER_LEVEL - 1);
    localparam tree_route_pkg::endpoint_addr_t UP_ADDR =
        with_digit(ROUTER_ADDR, ROUTER_LEVEL + 1, '0); // parent clears digit lv+1

    tree_route_pkg::port_t          port_c;
    tree_route_pkg::endpoint_addr_t next_addr_c;
    tree_route_pkg::level_t         next_level_c;
    logic                           endpoint_c;

    // ======================================================================
    // port and neighbor prediction
    // ======================================================================

    always_comb begin
        port_c = tree_route_pkg::nca_port(LEVEL_V, ROUTER_ADDR, dest_addr);
        if (port_c == UP_PORT) begin
            next_addr_c  = UP_ADDR;
            next_level_c = UP_LEVEL;
            endpoint_c   = 1'b0;
        end else begin
            next_addr_c  = with_digit(ROUTER_ADDR, ROUTER_LEVEL, port_c[KW-1:0]); // child j
            next_level_c = DOWN_LEVEL;
            endpoint_c   = (ROUTER_LEVEL == 0); // leaves eject to endpoints
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage.stage_valid <= 1'b0;
        end else begin
            stage.stage_valid <= launch; // follows launch by one cycle
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            stage.in_port          <= in_port;
            stage.dest_addr        <= dest_addr;
            stage.dest_port        <= port_c;
            stage.next_addr        <= next_addr_c;
            stage.next_level       <= next_level_c;
            stage.next_is_endpoint <= endpoint_c;
        end
    end

endmodule

// File: route/lookahead_route.sv
// second pipeline stage: routes at the predicted neighbor and builds the masked one-hot port vector
`timescale 1ns/10ps
`include "tree_route_defines.svh"

module lookahead_route #(
    parameter int ROUTER_LEVEL = 0
) (
    input  logic                       clk,
    input  logic                       reset,
    route_stage_if.consumer            stage,
    output tree_route_pkg::port_t      dest_port,
    output tree_route_pkg::port_mask_t port_mask,
    output tree_route_pkg::port_t      lk_port,
    output logic                       lk_eject,
    output logic                       result_valid
);

    // the root has no up port
    localparam int PORT_COUNT = (ROUTER_LEVEL == `TREE_L - 1) ? `TREE_K : `TREE_K + 1;
    localparam logic [`TREE_K:0] ONEHOT_ONE = 1;

    tree_route_pkg::port_t      lk_port_c;
    tree_route_pkg::port_mask_t mask_c;
    logic [`TREE_K:0]           port_onehot;

    // ======================================================================
    // look-ahead port
    // ======================================================================

    always_comb begin
        if (stage.next_is_endpoint) begin
            lk_port_c = '0; // endpoint has no router
        end else begin
            lk_port_c = tree_route_pkg::nca_port(stage.next_level, stage.next_addr,
                                                 stage.dest_addr);
        end
    end

    // ======================================================================
    // one-hot decode with the input port removed
    // ======================================================================

    always_comb begin
        port_onehot = '0;
        if (int'(stage.dest_port) < PORT_COUNT) begin
            port_onehot = ONEHOT_ONE << stage.dest_port;
        end
        // bits above in_port shift down one place
        for (int j = 0; j < `TREE_K; j++) begin
            if (j < int'(stage.in_port)) begin
                mask_c[j] = port_onehot[j];
            end else begin
                mask_c[j] = port_onehot[j+1];
            end
        end
    end

    // ======================================================================
    // result registers
    // ======================================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dest_port    <= '0;
            port_mask    <= '0;
            lk_port      <= '0;
            lk_eject     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= stage.stage_valid; // pulse back to the controller
            if (stage.stage_valid) begin
                dest_port <= stage.dest_port;
                port_mask <= mask_c;
                lk_port   <= lk_port_c;
                lk_eject  <= stage.next_is_endpoint;
            end
        end
    end

endmodule

// File: route/tree_route_unit.sv
// top level of the look-ahead route unit; connects the handshake controller and both route stages
`timescale 1ns/10ps

module tree_route_unit #(
    parameter int ROUTER_LEVEL = 0,
    parameter int ROUTER_POS   = 0
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req,
    output logic                           ack,
    input  tree_route_pkg::endpoint_addr_t dest_addr,
    input  tree_route_pkg::port_t          in_port,
    output tree_route_pkg::port_t          dest_port,
    output tree_route_pkg::port_mask_t     port_mask,
    output tree_route_pkg::port_t          lk_port,
    output logic                           lk_eject
);

    logic launch;       // one pulse per accepted request
    logic result_valid; // stage 2 has new results

    route_stage_if stage_bus ();

    four_phase_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .result_valid (result_valid),
        .launch       (launch),
        .ack          (ack)
    );

    nca_port_select #(
        .ROUTER_LEVEL (ROUTER_LEVEL),
        .ROUTER_POS   (ROUTER_POS)
    ) u_nca (
        .clk       (clk),
        .reset     (reset),
        .launch    (launch),
        .dest_addr (dest_addr),
        .in_port   (in_port),
        .stage     (stage_bus.producer)
    );

    lookahead_route #(
        .ROUTER_LEVEL (ROUTER_LEVEL)
    ) u_lookahead (
        .clk          (clk),
        .reset        (reset),
        .stage        (stage_bus.consumer),
        .dest_port    (dest_port),
        .port_mask    (port_mask),
        .lk_port      (lk_port),
        .lk_eject     (lk_eject),
        .result_valid (result_valid)
    );

endmodule

// File: testbench/tree_route_assertions.sv
// checker bound into the leaf route unit; models handshake timing and routing rules on each ack
`timescale 1ns/10ps
`include "tree_route_defines.svh"

module tree_route_assertions #(
    parameter int ROUTER_POS = 0
) (
    input logic                           clk,
    input logic                           reset,
    input logic                           req,
    input logic                           ack,
    input tree_route_pkg::endpoint_addr_t dest_addr,
    input tree_route_pkg::port_t          in_port,
    input tree_route_pkg::port_t          dest_port,
    input tree_route_pkg::port_mask_t     port_mask,
    input tree_route_pkg::port_t          lk_port,
    input logic                           lk_eject
);

    localparam int KW         = `TREE_KW;
    localparam int AW         = `TREE_L * `TREE_KW;
    localparam int UP_PORT    = `TREE_K;
    localparam int PORT_COUNT = `TREE_K + 1; // leaf keeps its up port
    localparam logic [AW-1:0] LEAF_ADDR   = AW'(ROUTER_POS * `TREE_K); // K a power of two
    localparam logic [AW-1:0] DIGIT1_MASK = AW'(((1 << KW) - 1) << KW);
    localparam logic [AW-1:0] PARENT_ADDR = LEAF_ADDR & ~DIGIT1_MASK; // digit 1 cleared
    localparam logic [`TREE_K-1:0] MASK_ONE = 1;

    int                 fail_count = 0;
    logic               accept;
    logic               in_flight;
    logic               release_q;   // DUT sits in its release state
    logic               release_d;
    logic [2:0]         accept_d;    // accept delayed by 1, 2 and 3 edges
    logic [AW-1:0]      dest_q;
    int                 in_q;
    int                 exp_port;
    int                 exp_lk;
    logic               exp_eject;
    logic [`TREE_K-1:0] exp_mask;

    // down on digit lv when all higher digits agree, otherwise up
    function automatic int expect_port(input int lv, input logic [AW-1:0] router,
                                       input logic [AW-1:0] dest);
        logic [AW-1:0] above;
        above = {AW{1'b1}} << ((lv + 1) * KW);
        if (((router ^ dest) & above) != '0) begin
            return UP_PORT;
        end
        return int'((dest >> (lv * KW)) & AW'((1 << KW) - 1));
    endfunction

    function automatic logic [`TREE_K-1:0] expect_mask(input int port, input int from);
        int slot;
        slot = (port < from) ? port : port - 1; // ports above the input move down one
        if (port == from || port >= PORT_COUNT || slot >= `TREE_K) begin
            return '0;
        end
        return MASK_ONE << slot;
    endfunction

    // ======================================================================
    // reference model
    // ======================================================================

    assign accept = req && !in_flight;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            in_flight <= 1'b0;
            release_q <= 1'b0;
            release_d <= 1'b0;
            accept_d  <= '0;
            dest_q    <= '0;
            in_q      <= 0;
        end else begin
            accept_d  <= {accept_d[1:0], accept};
            release_q <= in_flight && ack && !req && !release_q; // req seen low under ack
            release_d <= release_q;
            if (accept) begin
                in_flight <= 1'b1;
                dest_q    <= dest_addr;
                in_q      <= int'(in_port);
            end else if (release_q) begin
                in_flight <= 1'b0;
            end
        end
    end

    always_comb begin
        exp_port  = expect_port(0, LEAF_ADDR, dest_q);
        exp_eject = exp_port < UP_PORT;
        exp_lk    = exp_eject ? 0 : expect_port(1, PARENT_ADDR, dest_q);
        exp_mask  = expect_mask(exp_port, in_q);
    end

    // ======================================================================
    // handshake
    // ======================================================================

    a_reset_clear: assert property (@(posedge clk) reset |->
        (!ack && dest_port == '0 && port_mask == '0 && lk_port == '0 && !lk_eject))
    else begin
        fail_count++;
        $error("outputs are not all zero while reset is high");
    end

    a_idle_quiet: assert property (@(posedge clk) disable iff (reset) !in_flight |-> !ack)
    else begin
        fail_count++;
        $error("ack is high with no request in flight");
    end

    a_ack_latency: assert property (@(posedge clk) disable iff (reset)
        (|accept_d) |-> (ack == accept_d[2]))
    else begin
        fail_count++;
        $error("ack did not rise exactly two cycles after the request was taken");
    end

    a_ack_hold: assert property (@(posedge clk) disable iff (reset) (ack && req) |=> ack)
    else begin
        fail_count++;
        $error("ack dropped while req was still high");
    end

    a_ack_fall: assert property (@(posedge clk) disable iff (reset)
        (release_q || release_d) |-> (ack == release_q))
    else begin
        fail_count++;
        $error("ack did not fall one cycle after req was seen low");
    end

    // ======================================================================
    // routing results
    // ======================================================================

    a_dest_port: assert property (@(posedge clk) disable iff (reset)
        ack |-> (int'(dest_port) == exp_port))
    else begin
        fail_count++;
        $error("FAILED at %0t: dest_port = %0d, expected %0d",
               $time, $sampled(dest_port), $sampled(exp_port));
    end

    a_lk_eject: assert property (@(posedge clk) disable iff (reset) ack |-> (lk_eject == exp_eject))
    else begin
        fail_count++;
        $error("FAILED at %0t: lk_eject = %0b, expected %0b",
               $time, $sampled(lk_eject), $sampled(exp_eject));
    end

    a_lk_port: assert property (@(posedge clk) disable iff (reset) ack |-> (int'(lk_port) == exp_lk))
    else begin
        fail_count++;
        $error("FAILED at %0t: lk_port = %0d, expected %0d",
               $time, $sampled(lk_port), $sampled(exp_lk));
    end

    a_port_mask: assert property (@(posedge clk) disable iff (reset) ack |-> (port_mask == exp_mask))
    else begin
        fail_count++;
        $error("FAILED at %0t: port_mask = %b, expected %b",
               $time, $sampled(port_mask), $sampled(exp_mask));
    end

    a_results_stable: assert property (@(posedge clk) disable iff (reset)
        (ack && $past(ack)) |-> ($stable(dest_port) && $stable(port_mask) &&
                                 $stable(lk_port) && $stable(lk_eject)))
    else begin
        fail_count++;
        $error("results changed while ack was held high");
    end

endmodule

// File: testbench/tb_tree_route.sv
// testbench for a leaf route unit; LFSR-driven four-phase requests checked by the bound checker
`timescale 1ns/10ps
`include "tree_route_defines.svh"

module tb_tree_route;

    localparam int ROUTER_LEVEL = 0;
    localparam int ROUTER_POS   = 1;     // router address 2
    localparam int KW           = `TREE_KW;
    localparam int NUM_TRANS    = 200;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CYCLES   = 2000;  // 200 x 6 cycles plus reset and margin
    localparam logic [15:0] LFSR_SEED = 16'd31539;
    localparam tree_route_pkg::endpoint_addr_t LEAF_ADDR =
        tree_route_pkg::endpoint_addr_t'(ROUTER_POS * `TREE_K);

    logic                           clk;
    logic                           reset;
    logic                           req;
    logic                           ack;
    tree_route_pkg::endpoint_addr_t dest_addr;
    tree_route_pkg::port_t          in_port;
    tree_route_pkg::port_t          dest_port;
    tree_route_pkg::port_mask_t     port_mask;
    tree_route_pkg::port_t          lk_port;
    logic                           lk_eject;

    logic [15:0] lfsr_state        = LFSR_SEED;
    int          cycle_count       = 0;
    int          eject_count       = 0;
    int          parent_down_count = 0;
    int          parent_up_count   = 0;
    int          same_port_count   = 0;

    tree_route_unit #(
        .ROUTER_LEVEL (ROUTER_LEVEL),
        .ROUTER_POS   (ROUTER_POS)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .ack       (ack),
        .dest_addr (dest_addr),
        .in_port   (in_port),
        .dest_port (dest_port),
        .port_mask (port_mask),
        .lk_port   (lk_port),
        .lk_eject  (lk_eject)
    );

    bind tree_route_unit tree_route_assertions #(
        .ROUTER_POS (ROUTER_POS)
    ) u_checks (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .ack       (ack),
        .dest_addr (dest_addr),
        .in_port   (in_port),
        .dest_port (dest_port),
        .port_mask (port_mask),
        .lk_port   (lk_port),
        .lk_eject  (lk_eject)
    );

    // ======================================================================
    // clock and watchdogs
    // ======================================================================

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("RESULT: FAIL");
            $fatal(1, "timeout after %0d cycles before all transactions finished", cycle_count);
        end
    end

    // checker action blocks have settled by the falling edge
    always @(negedge clk) begin
        if (uut.u_checks.fail_count != 0) begin
            $display("RESULT: FAIL");
            $fatal(1, "the route checker reported an assertion failure");
        end
    end

    // ======================================================================
    // stimulus helpers
    // ======================================================================

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // x^16 + x^14 + x^13 + x^11 + 1
    endfunction

    task automatic draw_bits(input int count, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value[i]   = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic wait_for_ack(input logic level);
        do begin
            @(posedge clk);
            #1;
        end while (ack !== level);
    endtask

    // tally which routing cases the stimulus reaches
    task automatic record_case(input tree_route_pkg::endpoint_addr_t addr,
                               input tree_route_pkg::port_t from);
        logic                  down;
        tree_route_pkg::port_t out_port;
        down     = (addr >> KW) == (LEAF_ADDR >> KW);
        out_port = down ? tree_route_pkg::port_t'(addr[KW-1:0]) : tree_route_pkg::port_t'(`TREE_K);
        if (down) begin
            eject_count++;
        end else if ((addr >> (2 * KW)) == (LEAF_ADDR >> (2 * KW))) begin
            parent_down_count++;
        end else begin
            parent_up_count++;
        end
        if (from == out_port) begin
            same_port_count++;
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic run_transaction();
        logic [7:0] addr_bits;
        logic [7:0] port_bits;
        logic [7:0] hold_bits;
        draw_bits(`TREE_L * `TREE_KW, addr_bits);
        draw_bits(`TREE_PW, port_bits);
        draw_bits(1, hold_bits);
        dest_addr = tree_route_pkg::endpoint_addr_t'(addr_bits);
        in_port   = tree_route_pkg::port_t'(port_bits % (`TREE_K + 1)); // real ports only
        record_case(dest_addr, in_port);
        req = 1'b1;
        wait_for_ack(1'b1);
        if (hold_bits[0]) begin
            @(posedge clk); // requester stalls, ack must hold
            #1;
        end
        req = 1'b0;
        wait_for_ack(1'b0);
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================

    initial begin
        reset     = 1'b1;
        req       = 1'b0;
        dest_addr = '0;
        in_port   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int n = 0; n < NUM_TRANS; n++) begin
            run_transaction();
        end
        repeat (3) @(posedge clk); // let the last checks fire
        #1;
        if (uut.u_checks.fail_count == 0 && eject_count > 0 && parent_down_count > 0 &&
            parent_up_count > 0 && same_port_count > 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "checker failures %0d, or a case missed: eject %0d, up %0d/%0d, same %0d",
                   uut.u_checks.fail_count, eject_count, parent_down_count, parent_up_count,
                   same_port_count);
        end
    end

endmodule

// File: tree_route.f
+incdir+common
common/tree_route_pkg.sv
common/route_stage_if.sv
logic/four_phase_ctrl.sv
route/nca_port_select.sv
route/lookahead_route.sv
route/tree_route_unit.sv
testbench/tree_route_assertions.sv
testbench/tb_tree_route.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_tree_route
FILELIST  := tree_route.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert --timescale 1ns/10ps -j 0
RUN_FLAGS := +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)
